/* design/free_list.sv */
`timescale 1ns/1ns

module free_list #(
   parameter int  LOG_DEPTH = 5,
   parameter type entry_t   = logic [LOG_DEPTH-1:0]
) (
   input  logic   clk,
   input  logic   rstn,

   input  logic   push,
   input  entry_t push_data,
   input  logic   pop,
   output entry_t pop_data,

   output logic   empty,
   output logic   full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   entry_t               mem [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_DEPTH+1)'(DEPTH);  // every index starts out free
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= entry_t'(i);
         end
      end else begin
         if (push) begin
            mem[wr_ptr] <= push_data;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign pop_data = mem[rd_ptr];
   assign empty    = (count == '0);
   assign full     = (count == (LOG_DEPTH+1)'(DEPTH));  // all indices returned

   // users must only take what is there and only return what they took
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) !(pop && empty));
   a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) !(push && full));

endmodule

/* design/ro_ar_split.sv */
`timescale 1ns/1ns

module ro_ar_split import ro_pkg::*; #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               req_valid,
   input  ro_req_t            req,
   output logic               req_ready,

   input  logic               thread_empty,
   input  thread_id_t         thread_id,
   output logic               thread_pop,

   input  logic               tag_empty,
   input  logic [ID_BITS-1:0] tag,
   output logic               tag_pop,

   output logic               arvalid,
   input  logic               arready,
   output addr_t              araddr,
   output logic [ID_BITS-1:0] arid,

   output ro_mshr_t           mshr_wr,
   output ro_ctx_t            ctx_wr,
   output thread_id_t         ctx_thread,
   output logic               ctx_we
);

   localparam int OFS_BITS = $clog2(LINE_BYTES);

   logic       busy;
   addr_t      cur_addr;
   count_t     words_left;
   count_t     word_idx;     // index of the first word of the next read
   thread_id_t cur_thread;

   word_pos_t             pos;
   count_t                room;
   count_t                rd_words;
   logic                  last_read;
   logic [LINE_WORDS-1:0] mask;
   addr_t                 line_base;
   logic                  ar_hs;
   logic                  accept;

   always_comb begin
      pos       = cur_addr[OFS_BITS-1:2];
      room      = count_t'(LINE_WORDS) - count_t'(pos);  // words to end of line
      last_read = (words_left <= room);
      rd_words  = last_read ? words_left : room;
      line_base = cur_addr & ~addr_t'(LINE_BYTES - 1);
      for (int i = 0; i < LINE_WORDS; i++) begin
         mask[i] = (count_t'(i) >= count_t'(pos)) &&
                   (count_t'(i) < count_t'(pos) + rd_words);
      end
   end

   assign arvalid = busy && !tag_empty;
   assign araddr  = cur_addr;
   assign arid    = tag;
   assign ar_hs   = arvalid && arready;
   assign tag_pop = ar_hs;

   // a new request can slip in while the last read of the old one goes out
   assign req_ready  = !thread_empty && (!busy || (ar_hs && last_read));
   assign accept     = req_valid && req_ready;
   assign thread_pop = accept;

   assign ctx_we     = accept;
   assign ctx_thread = thread_id;
   assign ctx_wr     = '{payload: req.payload, remaining: req.n_words};

   assign mshr_wr = '{thread: cur_thread, valid_words: mask, start_idx: word_idx};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (ar_hs && last_read) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req.addr;
         words_left <= req.n_words;
         word_idx   <= '0;
         cur_thread <= thread_id;
      end else if (ar_hs) begin
         cur_addr   <= line_base + addr_t'(LINE_BYTES);  // next line start
         words_left <= words_left - rd_words;
         word_idx   <= word_idx + rd_words;
      end
   end

   a_req_nonzero: assert property (@(posedge clk) disable iff (!rstn)
      accept |-> req.n_words != '0);

endmodule

/* design/ro_pkg.sv */
package ro_pkg;

   localparam int LINE_WORDS = 16;
   localparam int LINE_BYTES = LINE_WORDS * 4;
   localparam int N_THREADS  = 4;

   typedef logic [31:0]                    word_t;
   typedef logic [LINE_WORDS*32-1:0]       line_t;
   typedef logic [31:0]                    addr_t;
   typedef logic [7:0]                     count_t;
   typedef logic [$clog2(N_THREADS)-1:0]   thread_id_t;
   typedef logic [15:0]                    payload_t;
   typedef logic [$clog2(LINE_WORDS)-1:0]  word_pos_t;

   typedef struct packed {
      addr_t    addr;     // byte address of the first word
      count_t   n_words;  // 1..255
      payload_t payload;
   } ro_req_t;

   typedef struct packed {
      payload_t payload;
      count_t   word_idx;
      word_t    data;
      logic     last;
   } ro_out_t;

   // one entry per outstanding read tag
   typedef struct packed {
      thread_id_t            thread;
      logic [LINE_WORDS-1:0] valid_words;
      count_t                start_idx;   // word index of the lowest valid word
   } ro_mshr_t;

   typedef struct packed {
      payload_t payload;
      count_t   remaining;  // words still to be emitted
   } ro_ctx_t;

endpackage

/* design/ro_read_engine.sv */
`timescale 1ns/1ns

module ro_read_engine import ro_pkg::*; #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               req_valid,
   input  ro_req_t            req,
   output logic               req_ready,

   output logic               arvalid,
   input  logic               arready,
   output addr_t              araddr,
   output logic [ID_BITS-1:0] arid,

   input  logic               rvalid,
   output logic               rready,
   input  logic [ID_BITS-1:0] rid,
   input  line_t              rdata,

   output logic               out_valid,
   input  logic               out_ready,
   output ro_out_t            out,

   output logic               idle
);

   typedef logic [ID_BITS-1:0] tag_t;

   logic       tag_push;
   tag_t       tag_free;
   logic       tag_pop;
   tag_t       tag;
   logic       tag_empty;

   logic       thread_push;
   thread_id_t thread_free;
   logic       thread_pop;
   thread_id_t thread_id;
   logic       thread_empty;

   ro_mshr_t   mshr_wr;
   ro_ctx_t    ctx_wr;
   thread_id_t ctx_thread;
   logic       ctx_we;

   free_list #(
      .LOG_DEPTH (ID_BITS),
      .entry_t   (tag_t)
   ) tag_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (tag_push),
      .push_data (tag_free),
      .pop       (tag_pop),
      .pop_data  (tag),
      .empty     (tag_empty),
      .full      ()
   );

   free_list #(
      .LOG_DEPTH ($clog2(N_THREADS)),
      .entry_t   (thread_id_t)
   ) thread_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (thread_push),
      .push_data (thread_free),
      .pop       (thread_pop),
      .pop_data  (thread_id),
      .empty     (thread_empty),
      .full      (idle)         // every slot back home
   );

   ro_ar_split #(
      .ID_BITS (ID_BITS)
   ) split (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req          (req),
      .req_ready    (req_ready),
      .thread_empty (thread_empty),
      .thread_id    (thread_id),
      .thread_pop   (thread_pop),
      .tag_empty    (tag_empty),
      .tag          (tag),
      .tag_pop      (tag_pop),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .mshr_wr      (mshr_wr),
      .ctx_wr       (ctx_wr),
      .ctx_thread   (ctx_thread),
      .ctx_we       (ctx_we)
   );

   ro_resp_unpack #(
      .ID_BITS (ID_BITS)
   ) unpack (
      .clk         (clk),
      .rstn        (rstn),
      .mshr_we     (tag_pop),     // entry is stored on the AR handshake
      .mshr_tag    (tag),
      .mshr_wr     (mshr_wr),
      .ctx_we      (ctx_we),
      .ctx_thread  (ctx_thread),
      .ctx_wr      (ctx_wr),
      .rvalid      (rvalid),
      .rready      (rready),
      .rid         (rid),
      .rdata       (rdata),
      .tag_push    (tag_push),
      .tag_free    (tag_free),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out         (out),
      .thread_push (thread_push),
      .thread_free (thread_free)
   );

endmodule

/* design/ro_resp_unpack.sv */
`timescale 1ns/1ns

module ro_resp_unpack import ro_pkg::*; #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               mshr_we,
   input  logic [ID_BITS-1:0] mshr_tag,
   input  ro_mshr_t           mshr_wr,

   input  logic               ctx_we,
   input  thread_id_t         ctx_thread,
   input  ro_ctx_t            ctx_wr,

   input  logic               rvalid,
   output logic               rready,
   input  logic [ID_BITS-1:0] rid,
   input  line_t              rdata,

   output logic               tag_push,
   output logic [ID_BITS-1:0] tag_free,

   output logic               out_valid,
   input  logic               out_ready,
   output ro_out_t            out,

   output logic               thread_push,
   output thread_id_t         thread_free
);

   ro_mshr_t mshr_tab [2**ID_BITS];
   ro_ctx_t  ctx_tab [N_THREADS];

   logic                  r_valid;
   line_t                 r_data;
   logic [LINE_WORDS-1:0] r_mask;     // words of the line still to emit
   thread_id_t            r_thread;
   count_t                r_idx;

   logic [LINE_WORDS-1:0] next_mask;
   word_pos_t             sel_pos;
   ro_ctx_t               cur_ctx;
   logic                  r_hs;
   logic                  out_hs;

   always_ff @(posedge clk) begin
      if (mshr_we) begin
         mshr_tab[mshr_tag] <= mshr_wr;
      end
   end

   always_ff @(posedge clk) begin
      for (int t = 0; t < N_THREADS; t++) begin
         if (ctx_we && ctx_thread == thread_id_t'(t)) begin
            ctx_tab[t] <= ctx_wr;
         end else if (out_hs && r_thread == thread_id_t'(t)) begin
            ctx_tab[t].remaining <= ctx_tab[t].remaining - 1'b1;
         end
      end
   end

   // pick the lowest word still pending
   always_comb begin
      sel_pos = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (r_mask[i]) begin
            sel_pos = word_pos_t'(i);
         end
      end
      next_mask          = r_mask;
      next_mask[sel_pos] = 1'b0;
   end

   assign cur_ctx   = ctx_tab[r_thread];
   assign out_valid = r_valid;  // a loaded line always has a word left
   assign out_hs    = out_valid && out_ready;

   assign out.payload  = cur_ctx.payload;
   assign out.word_idx = r_idx;
   assign out.data     = r_data[sel_pos*32 +: 32];
   assign out.last     = (cur_ctx.remaining == count_t'(1));

   assign rready = !r_valid || (out_hs && next_mask == '0);
   assign r_hs   = rvalid && rready;

   assign tag_push    = r_hs;
   assign tag_free    = rid;
   assign thread_push = out_hs && out.last;
   assign thread_free = r_thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         r_valid <= 1'b0;
      end else if (r_hs) begin
         r_valid <= 1'b1;
      end else if (out_hs && next_mask == '0) begin
         r_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_hs) begin
         r_data   <= rdata;
         r_mask   <= mshr_tab[rid].valid_words;
         r_thread <= mshr_tab[rid].thread;
         r_idx    <= mshr_tab[rid].start_idx;
      end else if (out_hs) begin
         r_mask <= next_mask;
         r_idx  <= r_idx + 1'b1;
      end
   end

   a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

/* dv/ro_mem_model.sv */
`timescale 1ns/1ns

module ro_mem_model import ro_pkg::*; #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               arvalid,
   output logic               arready,
   input  addr_t              araddr,
   input  logic [ID_BITS-1:0] arid,
   output logic               rvalid,
   input  logic               rready,
   output logic [ID_BITS-1:0] rid,
   output line_t              rdata
);

   addr_t              addr_q [$];
   logic [ID_BITS-1:0] id_q [$];
   int                 gap = 0;        // cycles left before the next response
   logic               rvalid_q = 1'b0;
   logic [ID_BITS-1:0] rid_q = '0;
   line_t              rdata_q = '0;
   addr_t              base;

   assign arready = 1'b1;  // queue takes every read
   assign rvalid  = rvalid_q;
   assign rid     = rid_q;
   assign rdata   = rdata_q;

   always @(posedge clk) begin
      if (!rstn) begin
         rvalid_q <= 1'b0;
         gap      <= 0;
         addr_q.delete();
         id_q.delete();
      end else begin
         if (arvalid && arready) begin
            addr_q.push_back(araddr);
            id_q.push_back(arid);
         end
         if (!rvalid_q || rready) begin
            rvalid_q <= 1'b0;
            if (addr_q.size() != 0 && gap == 0) begin
               base  = addr_q.pop_front() & ~addr_t'(LINE_BYTES - 1);
               rid_q <= id_q.pop_front();
               for (int i = 0; i < LINE_WORDS; i++) begin
                  rdata_q[i*32 +: 32] <= base + addr_t'(4 * i);  // word data is its address
               end
               rvalid_q <= 1'b1;
               gap      <= int'($urandom_range(0, 5));
            end else if (addr_q.size() != 0) begin
               gap <= gap - 1;
            end
         end
      end
   end

endmodule

/* dv/ro_tb.sv */
`timescale 1ns/1ns

module ro_tb import ro_pkg::*; ();

   localparam int ID_BITS       = 5;
   localparam int N_REQ         = 11;
   localparam int REQ_TIMEOUT   = 5000;
   localparam int DRAIN_TIMEOUT = 20000;
   localparam int IDLE_TIMEOUT  = 100;

   // address, word count, payload
   localparam ro_req_t STIM [N_REQ] = '{
      '{32'h0000_1000, 8'd1,   16'h0a01},  // one word
      '{32'h0000_2008, 8'd5,   16'h0a02},  // inside one line
      '{32'h0000_303c, 8'd4,   16'h0a03},  // crosses into the next line
      '{32'h0000_4000, 8'd16,  16'h0a04},
      '{32'h0000_5024, 8'd100, 16'h0a05},
      '{32'h0001_0010, 8'd255, 16'h0a06},
      // more long requests than thread slots
      '{32'h0002_0000, 8'd80,  16'h0b01},
      '{32'h0002_1004, 8'd80,  16'h0b02},
      '{32'h0002_2038, 8'd80,  16'h0b03},
      '{32'h0002_3000, 8'd80,  16'h0b04},
      '{32'h0002_40fc, 8'd80,  16'h0b05}
   };

   logic               clk = 1'b0;
   logic               rstn = 1'b0;
   logic               req_valid = 1'b0;
   ro_req_t            req = '0;
   logic               req_ready;
   logic               arvalid;
   logic               arready;
   addr_t              araddr;
   logic [ID_BITS-1:0] arid;
   logic               rvalid;
   logic               rready;
   logic [ID_BITS-1:0] rid;
   line_t              rdata;
   logic               out_valid;
   logic               out_ready = 1'b0;
   ro_out_t            out;
   logic               idle;

   ro_out_t exp_q [$];
   addr_t   exp_ar_q [$];
   int      accepted = 0;
   int      completed = 0;
   logic    saw_stall = 1'b0;
   logic    held_valid = 1'b0;
   ro_out_t held_out;
   int      stretch = 0;
   logic    throttle = 1'b0;
   logic [2**ID_BITS-1:0] tag_busy = '0;  // tags with a read outstanding

   ro_read_engine #(.ID_BITS(ID_BITS)) dut_i (.*);
   ro_mem_model #(.ID_BITS(ID_BITS)) mem_i (.*);

   initial begin
      forever #4 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic queue_expected(input ro_req_t r);
      addr_t   ar;
      ro_out_t w;
      ar = r.addr;
      while (ar < r.addr + 4 * addr_t'(r.n_words)) begin  // one read per line touched
         exp_ar_q.push_back(ar);
         ar = (ar & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);
      end
      for (int i = 0; i < int'(r.n_words); i++) begin
         w.payload  = r.payload;
         w.word_idx = count_t'(i);
         w.data     = r.addr + addr_t'(4 * i);
         w.last     = (i == int'(r.n_words) - 1);
         exp_q.push_back(w);
      end
   endtask

   // stretches of random back-pressure between stretches of full speed
   always @(posedge clk) begin
      if (stretch == 0) begin
         throttle <= ($urandom_range(0, 1) == 1);
         stretch  <= int'($urandom_range(20, 80));
      end else begin
         stretch <= stretch - 1;
      end
      out_ready <= throttle ? ($urandom_range(0, 1) == 1) : 1'b1;
   end

   always @(posedge clk) begin
      ro_out_t exp_word;
      if (rstn) begin
         check_eq("idle", idle, accepted == completed);  // before this edge's transfers
         if (accepted - completed == N_THREADS) begin
            check_eq("req_ready", req_ready, 1'b0);  // every thread slot taken
            if (req_valid) begin
               saw_stall = 1'b1;
            end
         end
         if (req_valid && req_ready) begin
            accepted++;
         end
         if (rvalid && rready) begin
            tag_busy[rid] = 1'b0;
         end
         if (arvalid && arready) begin
            if (tag_busy[arid]) begin
               report_failure("a read was issued with a tag that was still in use");
            end else if (exp_ar_q.size() == 0) begin
               report_failure("a read was issued with no address left to expect");
            end else begin
               check_eq("araddr", araddr, exp_ar_q.pop_front());
            end
            tag_busy[arid] = 1'b1;
         end
         if (held_valid) begin
            check_eq("out held", {out_valid, out}, {1'b1, held_out});
         end
         held_valid = out_valid && !out_ready;
         held_out   = out;
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               report_failure("an output word arrived with no word expected");
            end else begin
               exp_word = exp_q.pop_front();
               check_eq("out", out, exp_word);
               completed = completed + int'(out.last);
            end
         end
      end
   end

   initial begin
      int t;
      void'($urandom(32'hdd6b));
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      check_eq("idle after reset", idle, 1'b1);
      for (int k = 0; k < N_REQ; k++) begin
         req_valid <= 1'b1;
         req       <= STIM[k];
         queue_expected(STIM[k]);
         t = 0;
         do begin
            @(posedge clk);
            t++;
            if (t > REQ_TIMEOUT) begin
               report_failure($sformatf("timeout waiting for request %0d to be accepted", k));
            end
         end while (!req_ready);
      end
      req_valid <= 1'b0;
      t = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         t++;
         if (t > DRAIN_TIMEOUT) begin
            report_failure("timeout waiting for the remaining output words");
         end
      end
      t = 0;
      while (!idle) begin
         @(negedge clk);
         t++;
         if (t > IDLE_TIMEOUT) begin
            report_failure("engine did not return to idle after the last word");
         end
      end
      if (exp_ar_q.size() != 0) begin
         report_failure("some expected reads were never issued");
      end else if (!saw_stall) begin
         report_failure("req_ready never fell while all thread slots were busy");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module ro_tb -f tb.f
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi
sim_out=$(./obj_dir/Vro_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation returned an error"
   exit 1
fi
if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

/* tb.f */
design/ro_pkg.sv
design/free_list.sv
design/ro_ar_split.sv
design/ro_resp_unpack.sv
design/ro_read_engine.sv
dv/ro_mem_model.sv
dv/ro_tb.sv
